/* list.f */
hdl/ll_pkg.sv
hdl/offload_pkg.sv
hdl/ll_tx_parser.sv
hdl/word_fifo.sv
hdl/ll_rx_framer.sv
hdl/dcr_status.sv
hdl/offload_unit.sv
tests/tb_offload_unit.sv

/* tests/tb_offload_unit.sv */
`timescale 1ns/1ps

module tb_offload_unit
   import ll_pkg::*, offload_pkg::*;
();

   // payload words per frame without the header words
   localparam int LEN_EVEN    = 6;
   localparam int LEN_ODD     = 5;
   localparam int LEN_BP_A    = 4;
   localparam int LEN_BP_B    = 7;
   localparam int LEN_BP_C    = 1;
   localparam int LEN_DROP    = 3;
   localparam int LEN_STALL   = 2;
   localparam int LEN_AFTER   = 2;
   localparam int TOTAL_WORDS = 8 * HDR_WORDS + LEN_EVEN + LEN_ODD + LEN_BP_A + LEN_BP_B
                                + LEN_BP_C + LEN_DROP + LEN_STALL + LEN_AFTER;
   localparam int WATCHDOG_CYCLES = 200 * TOTAL_WORDS + 500;

   localparam ll_frame_t IDLE_BEAT = '{data: '0, rem: REM_ALL, sof_n: 1'b1, eof_n: 1'b1,
                                       sop_n: 1'b1, eop_n: 1'b1, src_rdy_n: 1'b1};

   logic                  clk;
   logic                  rst_n;
   ll_frame_t             tx_i;
   logic                  tx_dst_rdy_n_o;
   ll_frame_t             rx_o;
   logic                  rx_dst_rdy_n_i;
   logic                  rst_engine_ack_i;
   logic                  rst_engine_req_o;
   logic [DCR_ADDR_W-1:0] dcr_addr_i;
   logic [31:0]           dcr_wdata_i;
   logic                  dcr_read_i;
   logic                  dcr_write_i;
   logic                  dcr_ack_o;
   logic [31:0]           dcr_rdata_o;

   ll_frame_t   tx_q [$];
   ll_frame_t   exp_q [$];
   ll_frame_t   got_q [$];
   logic [31:0] lfsr = 32'hbaaa_a14f;
   logic        gaps_on;
   int          err_cnt;
   int          test_cnt;
   int          test_err_base;
   logic [2:0]  last_flags;
   logic [31:0] last_len;
   logic [9:0]  last_task;

   offload_unit u_offload_unit (
      .clk              (clk),
      .rst_n            (rst_n),
      .tx_i             (tx_i),
      .tx_dst_rdy_n_o   (tx_dst_rdy_n_o),
      .rx_o             (rx_o),
      .rx_dst_rdy_n_i   (rx_dst_rdy_n_i),
      .rst_engine_ack_i (rst_engine_ack_i),
      .rst_engine_req_o (rst_engine_req_o),
      .dcr_addr_i       (dcr_addr_i),
      .dcr_wdata_i      (dcr_wdata_i),
      .dcr_read_i       (dcr_read_i),
      .dcr_write_i      (dcr_write_i),
      .dcr_ack_o        (dcr_ack_o),
      .dcr_rdata_o      (dcr_rdata_o)
   );

   initial begin
      clk = 1'b0;
      forever #10 clk = ~clk;
   end

   initial begin
      repeat (WATCHDOG_CYCLES) @(posedge clk);
      $display("watchdog expired after %0d cycles, the run did not finish", WATCHDOG_CYCLES);
      $display("*** TEST FAILED ***");
      $finish;
   end

   // galois form with taps 32 22 2 1
   function automatic logic lfsr_bit();
      logic out;
      out  = lfsr[0];
      lfsr = lfsr >> 1;
      if (out) begin
         lfsr = lfsr ^ 32'h8020_0003;
      end
      return out;
   endfunction

   function automatic logic [31:0] rand_bits(input int n);
      logic [31:0] v;
      v = '0;
      for (int i = 0; i < n; i++) begin
         v = {v[30:0], lfsr_bit()};
      end
      return v;
   endfunction

   function automatic int valid_bytes(input logic [3:0] rem);
      case (rem)
         4'b0001: return 3;
         4'b0011: return 2;
         4'b0111: return 1;
         default: return 4;
      endcase
   endfunction

   task automatic flag_error(input string msg);
      err_cnt++;
      $display("ERROR @%0t: %s", $time, msg);
   endtask

   task automatic finish_test(input string name);
      test_cnt++;
      $display("%s finished with %0d errors", name, err_cnt - test_err_base);
      test_err_base = err_cnt;
   endtask

   // queue one TX frame and the RX beats it should produce
   task automatic build_frame(input logic [2:0] flags, input int n_words,
                              input logic [3:0] last_rem, input logic [9:0] task_idx);
      ll_frame_t w;
      ll_frame_t r;
      logic      copy;
      copy       = (flags == OP_COPY);
      last_flags = flags;
      last_len   = 32'(n_words * 4 - (4 - valid_bytes(last_rem)));
      last_task  = task_idx;
      for (int i = 0; i < HDR_WORDS; i++) begin
         w           = IDLE_BEAT;
         w.src_rdy_n = 1'b0;
         w.data      = rand_bits(32);
         w.sof_n     = (i != 0);
         if (i == HDR_FLAG_IDX) begin
            w.data[31:29] = flags;
         end
         if (i == HDR_LEN_IDX) begin
            w.data = last_len;
         end
         if (i == HDR_TASK_IDX) begin
            w.data[9:0] = task_idx;
         end
         tx_q.push_back(w);
      end
      for (int i = 0; i < n_words; i++) begin
         w           = IDLE_BEAT;
         w.src_rdy_n = 1'b0;
         w.data      = rand_bits(32);
         w.sop_n     = (i != 0);
         if (i == n_words - 1) begin
            w.eop_n = 1'b0;
            w.eof_n = 1'b0;
            w.rem   = last_rem;
         end
         tx_q.push_back(w);
         if (copy) begin
            r           = IDLE_BEAT;
            r.src_rdy_n = 1'b0;
            r.data      = w.data;
            if (i == n_words - 1) begin
               r.data = w.data & (32'hffff_ffff << (8 * (4 - valid_bytes(last_rem))));
               r.eop_n = (n_words % 2 != 0);
            end
            r.sof_n = (i != 0);
            r.sop_n = (i != 0);
            exp_q.push_back(r);
         end
      end
      r           = IDLE_BEAT;
      r.src_rdy_n = 1'b0;
      if (copy && (n_words % 2 != 0)) begin
         // zero pad closes the last 64-bit entry
         r.eop_n = 1'b0;
         exp_q.push_back(r);
         r.eop_n = 1'b1;
      end
      r.data  = {flags, copy, 28'h0};
      r.sof_n = copy;
      exp_q.push_back(r);
      r.sof_n = 1'b1;
      r.data  = copy ? 32'(8 * ((n_words + 1) / 2)) : 32'h0;
      exp_q.push_back(r);
      r.data = {22'h0, task_idx};
      exp_q.push_back(r);
      r.data  = '0;
      r.eof_n = 1'b0;
      exp_q.push_back(r);
   endtask

   // beats sampled at the falling edge transfer on the next rising edge
   task automatic run_traffic(input int n_frames);
      ll_frame_t w;
      int        eofs;
      eofs = 0;
      while (eofs < n_frames || tx_q.size() > 0) begin
         @(negedge clk);
         rx_dst_rdy_n_i = gaps_on && (rand_bits(2) == 2'b11);
         if (!rx_o.src_rdy_n && !rx_dst_rdy_n_i) begin
            got_q.push_back(rx_o);
            if (!rx_o.eof_n) begin
               eofs++;
            end
         end
         if (tx_q.size() > 0) begin
            w = tx_q[0];
            if (gaps_on && (rand_bits(2) == 2'b11)) begin
               w.src_rdy_n = 1'b1;
            end
            tx_i = w;
            if (!w.src_rdy_n && !tx_dst_rdy_n_o) begin
               void'(tx_q.pop_front());
            end
         end else begin
            tx_i = IDLE_BEAT;
         end
      end
      @(negedge clk);
      tx_i           = IDLE_BEAT;
      rx_dst_rdy_n_i = 1'b0;
   endtask

   // leave a copy frame stuck behind a stalled RX port
   task automatic stall_frame(input int n_words);
      build_frame(OP_COPY, n_words, REM_ALL, 10'h2aa);
      exp_q.delete();
      while (tx_q.size() > 0) begin
         @(negedge clk);
         rx_dst_rdy_n_i = 1'b1;
         tx_i           = tx_q[0];
         if (!tx_dst_rdy_n_o) begin
            void'(tx_q.pop_front());
         end
      end
      @(negedge clk);
      tx_i = IDLE_BEAT;
      while (rx_o.src_rdy_n) begin
         @(negedge clk);
      end
   endtask

   task automatic check_rx();
      if (got_q.size() != exp_q.size()) begin
         flag_error($sformatf("rx frame has %0d beats, expected %0d",
                              got_q.size(), exp_q.size()));
      end
      for (int i = 0; i < got_q.size() && i < exp_q.size(); i++) begin
         if (got_q[i] !== exp_q[i]) begin
            flag_error($sformatf("rx beat %0d got %h sof/eof/sop/eop %b%b%b%b, exp %h %b%b%b%b",
                                 i, got_q[i].data, got_q[i].sof_n, got_q[i].eof_n,
                                 got_q[i].sop_n, got_q[i].eop_n, exp_q[i].data, exp_q[i].sof_n,
                                 exp_q[i].eof_n, exp_q[i].sop_n, exp_q[i].eop_n));
         end
      end
      got_q.delete();
      exp_q.delete();
   endtask

   task automatic dcr_read(input logic [DCR_ADDR_W-1:0] addr, input logic [31:0] expected);
      @(negedge clk);
      dcr_addr_i = addr;
      dcr_read_i = 1'b1;
      @(negedge clk);
      dcr_read_i = 1'b0;
      if (dcr_ack_o !== 1'b1) begin
         flag_error($sformatf("no dcr ack one cycle after read of %0d", addr));
      end
      if (dcr_rdata_o !== expected) begin
         flag_error($sformatf("dcr %0d read %h, expected %h", addr, dcr_rdata_o, expected));
      end
      @(negedge clk);
      if (dcr_ack_o !== 1'b0) begin
         flag_error("dcr ack held longer than one cycle");
      end
   endtask

   task automatic dcr_write(input logic [31:0] data, input logic expect_req);
      @(negedge clk);
      dcr_addr_i  = '0;
      dcr_wdata_i = data;
      dcr_write_i = 1'b1;
      @(negedge clk);
      dcr_write_i = 1'b0;
      if (dcr_ack_o !== 1'b1) begin
         flag_error("no dcr ack one cycle after write");
      end
      if (rst_engine_req_o !== expect_req) begin
         flag_error($sformatf("engine reset request %b, expected %b",
                              rst_engine_req_o, expect_req));
      end
      @(negedge clk);
      if (rst_engine_req_o !== 1'b0) begin
         flag_error("engine reset request held longer than one cycle");
      end
   endtask

   task automatic test_reset_state();
      if (tx_dst_rdy_n_o !== 1'b0) begin
         flag_error("tx dst_rdy_n not low after reset");
      end
      if ({rx_o.src_rdy_n, rx_o.sof_n, rx_o.eof_n, rx_o.sop_n, rx_o.eop_n} !== 5'b11111) begin
         flag_error("rx control bits not all high after reset");
      end
      if (dcr_ack_o !== 1'b0 || rst_engine_req_o !== 1'b0) begin
         flag_error("dcr ack or engine reset request active after reset");
      end
      finish_test("reset_state");
   endtask

   task automatic test_copy_even();
      build_frame(OP_COPY, LEN_EVEN, REM_ALL, 10'h15a);
      run_traffic(1);
      check_rx();
      finish_test("copy_even");
   endtask

   task automatic test_copy_odd();
      build_frame(OP_COPY, LEN_ODD, REM_2B, 10'h2c3);
      run_traffic(1);
      check_rx();
      finish_test("copy_odd");
   endtask

   task automatic test_back_pressure();
      gaps_on = 1'b1;
      build_frame(OP_COPY, LEN_BP_A, REM_ALL, 10'h001);
      build_frame(OP_COPY, LEN_BP_B, REM_1B, 10'h3ff);
      build_frame(OP_COPY, LEN_BP_C, REM_3B, 10'h0a5);
      run_traffic(3);
      gaps_on = 1'b0;
      check_rx();
      finish_test("back_pressure");
   endtask

   task automatic test_unsupported();
      build_frame(OP_COMP, LEN_DROP, REM_ALL, 10'h3e1);
      run_traffic(1);
      check_rx();
      finish_test("unsupported_op");
   endtask

   task automatic test_dcr();
      dcr_read(DCR_ID, DCR_ID_VALUE);
      dcr_read(DCR_PATTERN, DCR_PATTERN_VALUE);
      dcr_read(DCR_LEN, last_len);
      dcr_read(DCR_DESC, {last_flags, 19'h0, last_task});
      dcr_read(7, 32'h0);
      dcr_write(32'h7fff_ffff, 1'b0);
      stall_frame(LEN_STALL);
      dcr_write(32'h8000_0000, 1'b1);
      if (rx_o.src_rdy_n !== 1'b1 || tx_dst_rdy_n_o !== 1'b0) begin
         flag_error("LocalLink ready state wrong after engine reset");
      end
      build_frame(OP_COPY, LEN_AFTER, REM_ALL, 10'h111);
      run_traffic(1);
      check_rx();
      finish_test("dcr");
   endtask

   initial begin
      rst_n            = 1'b0;
      tx_i             = IDLE_BEAT;
      rx_dst_rdy_n_i   = 1'b0;
      rst_engine_ack_i = 1'b0;
      dcr_addr_i       = '0;
      dcr_wdata_i      = '0;
      dcr_read_i       = 1'b0;
      dcr_write_i      = 1'b0;
      gaps_on          = 1'b0;
      err_cnt          = 0;
      test_cnt         = 0;
      test_err_base    = 0;
      repeat (4) @(negedge clk);
      rst_n = 1'b1;
      @(negedge clk);
      test_reset_state();
      test_copy_even();
      test_copy_odd();
      test_back_pressure();
      test_unsupported();
      test_dcr();
      $display("tests run %0d, errors %0d", test_cnt, err_cnt);
      if (err_cnt == 0) begin
         $display("*** TEST PASSED ***");
      end else begin
         $display("*** TEST FAILED ***");
      end
      $finish;
   end

endmodule

/* hdl/offload_unit.sv */
`timescale 1ns/1ps

module offload_unit
   import ll_pkg::*, offload_pkg::*;
(
   input  logic                  clk,
   input  logic                  rst_n,
   input  ll_frame_t             tx_i,
   output logic                  tx_dst_rdy_n_o,
   output ll_frame_t             rx_o,
   input  logic                  rx_dst_rdy_n_i,
   input  logic                  rst_engine_ack_i,
   output logic                  rst_engine_req_o,
   input  logic [DCR_ADDR_W-1:0] dcr_addr_i,
   input  logic [31:0]           dcr_wdata_i,
   input  logic                  dcr_read_i,
   input  logic                  dcr_write_i,
   output logic                  dcr_ack_o,
   output logic [31:0]           dcr_rdata_o
);

   logic   eng_rst_n;
   logic   push;
   logic   pop;
   logic   full;
   logic   empty;
   logic   desc_valid;
   logic   frame_done;
   entry_t push_entry;
   entry_t head_entry;
   desc_t  desc;

   // datapath reset, status port stays on rst_n
   assign eng_rst_n = rst_n && !rst_engine_req_o && !rst_engine_ack_i;

   ll_tx_parser u_tx_parser (
      .clk            (clk),
      .rst_n          (eng_rst_n),
      .tx_i           (tx_i),
      .tx_dst_rdy_n_o (tx_dst_rdy_n_o),
      .full_i         (full),
      .frame_done_i   (frame_done),
      .push_o         (push),
      .entry_o        (push_entry),
      .desc_o         (desc),
      .desc_valid_o   (desc_valid)
   );

   word_fifo #(
      .DEPTH (FIFO_DEPTH)
   ) u_word_fifo (
      .clk     (clk),
      .rst_n   (eng_rst_n),
      .push_i  (push),
      .entry_i (push_entry),
      .pop_i   (pop),
      .entry_o (head_entry),
      .empty_o (empty),
      .full_o  (full)
   );

   ll_rx_framer u_rx_framer (
      .clk            (clk),
      .rst_n          (eng_rst_n),
      .desc_i         (desc),
      .desc_valid_i   (desc_valid),
      .empty_i        (empty),
      .entry_i        (head_entry),
      .pop_o          (pop),
      .rx_o           (rx_o),
      .rx_dst_rdy_n_i (rx_dst_rdy_n_i),
      .frame_done_o   (frame_done)
   );

   dcr_status u_dcr_status (
      .clk              (clk),
      .rst_n            (rst_n),
      .dcr_addr_i       (dcr_addr_i),
      .dcr_wdata_i      (dcr_wdata_i),
      .dcr_read_i       (dcr_read_i),
      .dcr_write_i      (dcr_write_i),
      .desc_i           (desc),
      .dcr_ack_o        (dcr_ack_o),
      .dcr_rdata_o      (dcr_rdata_o),
      .rst_engine_req_o (rst_engine_req_o)
   );

endmodule

/* hdl/dcr_status.sv */
`timescale 1ns/1ps

module dcr_status
   import offload_pkg::*;
(
   input  logic                  clk,
   input  logic                  rst_n,
   input  logic [DCR_ADDR_W-1:0] dcr_addr_i,
   input  logic [31:0]           dcr_wdata_i,
   input  logic                  dcr_read_i,
   input  logic                  dcr_write_i,
   input  desc_t                 desc_i,
   output logic                  dcr_ack_o,
   output logic [31:0]           dcr_rdata_o,
   output logic                  rst_engine_req_o
);

   logic [31:0] rdata_mux;

   always_comb begin
      rdata_mux = '0;
      case (dcr_addr_i)
         DCR_DESC:    rdata_mux = {desc_i.flags, 19'h0, desc_i.task_index};
         DCR_LEN:     rdata_mux = desc_i.src_len;
         DCR_ID:      rdata_mux = DCR_ID_VALUE;
         DCR_PATTERN: rdata_mux = DCR_PATTERN_VALUE;
         default:     rdata_mux = '0;
      endcase
   end

   always_ff @(posedge clk) begin
      dcr_rdata_o <= dcr_read_i ? rdata_mux : '0;
   end

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         dcr_ack_o        <= 1'b0;
         rst_engine_req_o <= 1'b0;
      end else begin
         dcr_ack_o <= dcr_read_i || dcr_write_i;
         // bit 31 of a write to register 0 kicks the engine reset
         rst_engine_req_o <= dcr_write_i && (dcr_addr_i == '0) && dcr_wdata_i[31];
      end
   end

endmodule

/* hdl/ll_rx_framer.sv */
`timescale 1ns/1ps

module ll_rx_framer
   import ll_pkg::*, offload_pkg::*;
(
   input  logic      clk,
   input  logic      rst_n,
   input  desc_t     desc_i,
   input  logic      desc_valid_i,
   input  logic      empty_i,
   input  entry_t    entry_i,
   output logic      pop_o,
   output ll_frame_t rx_o,
   input  logic      rx_dst_rdy_n_i,
   output logic      frame_done_o
);

   rx_state_e                      state;
   desc_t                          desc_q;
   op_e                            op;
   logic                           cpl_pend;
   logic [$clog2(CPL_WORDS)-1:0]   cpl_idx;
   logic [31:0]                    byte_cnt;
   logic [LL_DATA_W-1:0]           cpl_word0;
   logic                           beat;

   function automatic op_e decode_op(input logic [2:0] flags);
      case (flags)
         3'b001:  return OP_COPY;
         3'b010:  return OP_DECOMP;
         3'b100:  return OP_COMP;
         default: return OP_NONE;
      endcase
   endfunction

   assign op           = decode_op(desc_q.flags);
   assign cpl_word0    = {desc_q.flags, op == OP_COPY, 28'h0};
   assign beat         = !rx_o.src_rdy_n && !rx_dst_rdy_n_i;
   assign pop_o        = (state == RX_PAYLOAD_LO) && beat;
   assign frame_done_o = (state == RX_DONE);

   always_ff @(posedge clk) begin
      if (desc_valid_i) begin
         desc_q <= desc_i;
      end
   end

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         state          <= RX_IDLE;
         cpl_pend       <= 1'b0;
         cpl_idx        <= '0;
         byte_cnt       <= '0;
         rx_o.src_rdy_n <= 1'b1;
         rx_o.sof_n     <= 1'b1;
         rx_o.eof_n     <= 1'b1;
         rx_o.sop_n     <= 1'b1;
         rx_o.eop_n     <= 1'b1;
      end else begin
         // dropped operation, answer with the completion only
         if (desc_valid_i && decode_op(desc_i.flags) != OP_COPY) begin
            cpl_pend <= 1'b1;
         end
         case (state)
            RX_IDLE: begin
               byte_cnt <= '0;
               cpl_idx  <= '0;
               if (!empty_i) begin
                  rx_o.data      <= entry_i.hi;
                  rx_o.rem       <= REM_ALL;
                  rx_o.sof_n     <= 1'b0;
                  rx_o.sop_n     <= 1'b0;
                  rx_o.src_rdy_n <= 1'b0;
                  state          <= RX_PAYLOAD_HI;
               end else if (cpl_pend) begin
                  cpl_pend       <= 1'b0;
                  rx_o.data      <= cpl_word0;
                  rx_o.rem       <= REM_ALL;
                  rx_o.sof_n     <= 1'b0;
                  rx_o.src_rdy_n <= 1'b0;
                  state          <= RX_CPL;
               end
            end
            RX_PAYLOAD_HI: begin
               if (beat) begin
                  rx_o.data  <= entry_i.lo;
                  rx_o.sof_n <= 1'b1;
                  rx_o.sop_n <= 1'b1;
                  rx_o.eop_n <= !entry_i.last;
                  state      <= RX_PAYLOAD_LO;
               end else if (rx_o.src_rdy_n && !empty_i) begin
                  // next entry after a pop
                  rx_o.data      <= entry_i.hi;
                  rx_o.src_rdy_n <= 1'b0;
               end
            end
            RX_PAYLOAD_LO: begin
               if (beat) begin
                  byte_cnt   <= byte_cnt + 32'd8;
                  rx_o.eop_n <= 1'b1;
                  if (!rx_o.eop_n) begin
                     rx_o.data <= cpl_word0;
                     state     <= RX_CPL;
                  end else begin
                     rx_o.src_rdy_n <= 1'b1;
                     state          <= RX_PAYLOAD_HI;
                  end
               end
            end
            RX_CPL: begin
               if (beat) begin
                  rx_o.sof_n <= 1'b1;
                  if (cpl_idx == CPL_WORDS - 1) begin
                     rx_o.src_rdy_n <= 1'b1;
                     rx_o.eof_n     <= 1'b1;
                     state          <= RX_DONE;
                  end else begin
                     cpl_idx <= cpl_idx + 1'b1;
                     case (cpl_idx)
                        2'd0: rx_o.data <= byte_cnt;
                        2'd1: rx_o.data <= {22'h0, desc_q.task_index};
                        default: begin
                           rx_o.data  <= '0;
                           rx_o.eof_n <= 1'b0;
                        end
                     endcase
                  end
               end
            end
            RX_DONE: state <= RX_IDLE;
            default: state <= RX_IDLE;
         endcase
      end
   end

endmodule

/* hdl/word_fifo.sv */
`timescale 1ns/1ps

module word_fifo
   import offload_pkg::*;
#(
   parameter int DEPTH = FIFO_DEPTH
) (
   input  logic   clk,
   input  logic   rst_n,
   input  logic   push_i,
   input  entry_t entry_i,
   input  logic   pop_i,
   output entry_t entry_o,
   output logic   empty_o,
   output logic   full_o
);

   entry_t                       mem [DEPTH];
   logic [$clog2(DEPTH)-1:0]     wr_ptr;
   logic [$clog2(DEPTH)-1:0]     rd_ptr;
   logic [$clog2(DEPTH+1)-1:0]   count;
   logic                         wr_en;
   logic                         rd_en;

   assign wr_en   = push_i && (count != DEPTH);
   assign rd_en   = pop_i && !empty_o;
   assign empty_o = (count == 0);
   // the parser may have one push in flight behind a beat
   assign full_o  = (count == DEPTH) || ((count == DEPTH - 1) && push_i);

   // show-ahead head entry
   assign entry_o = mem[rd_ptr];

   always_ff @(posedge clk) begin
      if (wr_en) begin
         mem[wr_ptr] <= entry_i;
      end
   end

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (wr_en) begin
            wr_ptr <= (wr_ptr == DEPTH - 1) ? '0 : wr_ptr + 1'b1;
         end
         if (rd_en) begin
            rd_ptr <= (rd_ptr == DEPTH - 1) ? '0 : rd_ptr + 1'b1;
         end
         case ({wr_en, rd_en})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;
         endcase
      end
   end

endmodule

/* hdl/ll_tx_parser.sv */
`timescale 1ns/1ps

module ll_tx_parser
   import ll_pkg::*, offload_pkg::*;
(
   input  logic      clk,
   input  logic      rst_n,
   input  ll_frame_t tx_i,
   output logic      tx_dst_rdy_n_o,
   input  logic      full_i,
   input  logic      frame_done_i,
   output logic      push_o,
   output entry_t    entry_o,
   output desc_t     desc_o,
   output logic      desc_valid_o
);

   tx_state_e                      state;
   logic [$clog2(HDR_WORDS)-1:0]   hdr_cnt;
   logic [LL_DATA_W-1:0]           hi_q;
   logic [LL_DATA_W-1:0]           word_masked;
   logic [LL_DATA_W-1:0]           payload_word;
   logic                           beat;
   logic                           is_copy;
   logic                           done_pend;

   assign tx_dst_rdy_n_o = full_i || (state == TX_WAIT);
   assign beat           = !tx_i.src_rdy_n && !tx_dst_rdy_n_o;
   assign is_copy        = (desc_o.flags == OP_COPY);

   // zero the bytes the remainder marks invalid
   always_comb begin
      case (tx_i.rem)
         REM_3B:  word_masked = {tx_i.data[31:8], 8'h00};
         REM_2B:  word_masked = {tx_i.data[31:16], 16'h0000};
         REM_1B:  word_masked = {tx_i.data[31:24], 24'h00_0000};
         default: word_masked = tx_i.data;
      endcase
   end

   // rem only matters on the last payload word
   assign payload_word = tx_i.eop_n ? tx_i.data : word_masked;

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         state        <= TX_IDLE;
         hdr_cnt      <= '0;
         push_o       <= 1'b0;
         desc_valid_o <= 1'b0;
         done_pend    <= 1'b0;
      end else begin
         push_o       <= 1'b0;
         desc_valid_o <= 1'b0;
         // completion may finish before the payload of a dropped frame
         if (frame_done_i && state != TX_WAIT) begin
            done_pend <= 1'b1;
         end
         case (state)
            TX_IDLE: begin
               if (beat && !tx_i.sof_n) begin
                  hdr_cnt <= 1'b1;
                  state   <= TX_HEAD;
               end
            end
            TX_HEAD: begin
               if (beat) begin
                  hdr_cnt <= hdr_cnt + 1'b1;
                  if (hdr_cnt == HDR_TASK_IDX) begin
                     desc_valid_o <= 1'b1;
                  end
                  if (hdr_cnt == HDR_WORDS - 1) begin
                     state <= TX_PAYLOAD_HI;
                  end
               end
            end
            TX_PAYLOAD_HI: begin
               if (beat) begin
                  if (!tx_i.eop_n) begin
                     push_o <= is_copy;
                     state  <= TX_WAIT;
                  end else begin
                     state <= TX_PAYLOAD_LO;
                  end
               end
            end
            TX_PAYLOAD_LO: begin
               if (beat) begin
                  push_o <= is_copy;
                  state  <= tx_i.eop_n ? TX_PAYLOAD_HI : TX_WAIT;
               end
            end
            TX_WAIT: begin
               if (frame_done_i || done_pend) begin
                  done_pend <= 1'b0;
                  state     <= TX_IDLE;
               end
            end
            default: state <= TX_IDLE;
         endcase
      end
   end

   // header fields and packed entries
   always_ff @(posedge clk) begin
      if (state == TX_HEAD && beat) begin
         if (hdr_cnt == HDR_FLAG_IDX) begin
            desc_o.flags <= tx_i.data[31:29];
         end
         if (hdr_cnt == HDR_LEN_IDX) begin
            desc_o.src_len <= tx_i.data;
         end
         if (hdr_cnt == HDR_TASK_IDX) begin
            desc_o.task_index <= tx_i.data[9:0];
         end
      end
      if (state == TX_PAYLOAD_HI && beat) begin
         hi_q <= payload_word;
         if (!tx_i.eop_n) begin
            // odd tail, lo stays zero
            entry_o <= '{hi: payload_word, lo: '0, last: 1'b1};
         end
      end
      if (state == TX_PAYLOAD_LO && beat) begin
         entry_o <= '{hi: hi_q, lo: payload_word, last: !tx_i.eop_n};
      end
   end

endmodule

/* hdl/offload_pkg.sv */
package offload_pkg;

   // TX header layout
   localparam int HDR_WORDS    = 8;
   localparam int HDR_FLAG_IDX = 4;
   localparam int HDR_LEN_IDX  = 5;
   localparam int HDR_TASK_IDX = 6;

   // completion trailer on RX
   localparam int CPL_WORDS = 4;

   // operation from flag bits 31:29
   typedef enum logic [2:0] {
      OP_NONE   = 3'b000,
      OP_COPY   = 3'b001,
      OP_DECOMP = 3'b010,
      OP_COMP   = 3'b100
   } op_e;

   typedef struct packed {
      logic [2:0]  flags;
      logic [31:0] src_len;
      logic [9:0]  task_index;
   } desc_t;

   typedef struct packed {
      logic [31:0] hi;
      logic [31:0] lo;
      logic        last;
   } entry_t;

   typedef enum logic [3:0] {
      TX_IDLE,
      TX_HEAD,
      TX_PAYLOAD_HI,
      TX_PAYLOAD_LO,
      TX_WAIT
   } tx_state_e;

   typedef enum logic [2:0] {
      RX_IDLE,
      RX_PAYLOAD_HI,
      RX_PAYLOAD_LO,
      RX_CPL,
      RX_DONE
   } rx_state_e;

   localparam int FIFO_DEPTH = 16;

   // status port map
   localparam int DCR_ADDR_W  = 10;
   localparam int DCR_DESC    = 2;
   localparam int DCR_LEN     = 5;
   localparam int DCR_ID      = 14;
   localparam int DCR_PATTERN = 15;

   localparam logic [31:0] DCR_ID_VALUE      = 32'h1006_0402;
   localparam logic [31:0] DCR_PATTERN_VALUE = 32'haa55_55aa;

endpackage

/* hdl/ll_pkg.sv */
package ll_pkg;

   // LocalLink beat geometry
   localparam int LL_DATA_W = 32;
   localparam int LL_REM_W  = 4;

   // remainder codes, count of valid leading bytes
   localparam logic [LL_REM_W-1:0] REM_ALL = 4'b0000;
   localparam logic [LL_REM_W-1:0] REM_3B  = 4'b0001;
   localparam logic [LL_REM_W-1:0] REM_2B  = 4'b0011;
   localparam logic [LL_REM_W-1:0] REM_1B  = 4'b0111;

   // one beat in the source direction, dst_rdy_n travels back separately
   typedef struct packed {
      logic [LL_DATA_W-1:0] data;
      logic [LL_REM_W-1:0]  rem;
      logic                 sof_n;
      logic                 eof_n;
      logic                 sop_n;
      logic                 eop_n;
      logic                 src_rdy_n;
   } ll_frame_t;

endpackage
